// ==== pcie_phy_pkg.sv ====
package pcie_phy_pkg;

  // lane count of the link
  localparam int NUM_LANES = 4;
  // symbols per packed word
  localparam int WORD_SYMS = 4;
  // word buffer depth and pointer width
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW = $clog2(FIFO_DEPTH);
  // idle data symbols in a row before idle is flagged
  localparam int IDLE_RUN = 8;
  // last symbol index of a training set
  localparam int TS_LAST = 15;

  // k codes
  localparam logic [7:0] SYM_COM = 8'hBC;
  localparam logic [7:0] SYM_SKP = 8'h1C;
  localparam logic [7:0] SYM_SDP = 8'h5C;
  localparam logic [7:0] SYM_END = 8'hFD;

  // training-set identifiers
  localparam logic [7:0] TS1_ID = 8'h4A;
  localparam logic [7:0] TS2_ID = 8'h45;

  // lfsr value loaded on com
  localparam logic [15:0] LFSR_SEED = 16'hFFFF;

  // one decoded symbol from a lane
  typedef struct packed {
    logic [7:0] data;
    logic       is_k;
    logic       valid;
  } lane_sym_t;

  // symbol inside a packed word, no valid bit
  typedef struct packed {
    logic [7:0] data;
    logic       is_k;
  } word_sym_t;

  // sym[0] is byte 0, first on the wire
  typedef struct packed {
    word_sym_t [WORD_SYMS-1:0] sym;
    logic                      valid;
  } phy_word_t;

  typedef enum logic [1:0] {
    WIDTH_X1 = 2'd0,
    WIDTH_X2 = 2'd1,
    WIDTH_X4 = 2'd2
  } link_width_e;

  // symbol 6 as seen in ts1
  typedef struct packed {
    logic [1:0] eq_ctrl;
    logic       reset_eieos;
    logic [3:0] tx_preset;
    logic       use_preset;
  } ts1_sym6_t;

  // symbol 6 as seen in ts2
  typedef struct packed {
    logic       req_eq;
    logic       quiesce;
    logic [3:0] eq_preset;
    logic [1:0] reserved;
  } ts2_sym6_t;

  // same byte, view picked by which ts it came in
  typedef union packed {
    ts1_sym6_t ts1;
    ts2_sym6_t ts2;
  } ts_sym6_u;

  typedef struct packed {
    logic [7:0] link_num;
    logic [7:0] lane_num;
    logic [7:0] n_fts;
    logic [7:0] rate_id;
    logic [7:0] training_ctrl;
    ts_sym6_u   sym6;
  } pcie_ordered_set_t;

  typedef struct packed {
    logic [31:0] tdata;
    logic [3:0]  tkeep;
    logic        tlast;
    logic        bad_end;
  } dllp_beat_t;

  // one shift of x16+x5+x4+x3+1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15]} ^ {10'b0, s[15], s[15], s[15], 3'b0};
  endfunction

  // lfsr state after one symbol, 8 shifts
  function automatic logic [15:0] lfsr_advance(input logic [15:0] s);
    logic [15:0] n;
    n = s;
    for (int i = 0; i < 8; i++) begin
      n = lfsr_step(n);
    end
    return n;
  endfunction

  // scramble byte for this state, bit 0 first
  function automatic logic [7:0] lfsr_key(input logic [15:0] s);
    logic [15:0] n;
    logic [7:0]  k;
    n = s;
    for (int i = 0; i < 8; i++) begin
      k[i] = n[15];
      n = lfsr_step(n);
    end
    return k;
  endfunction

endpackage

// ==== lane_descrambler.sv ====
module lane_descrambler (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  pcie_phy_pkg::lane_sym_t sym_i,
  output pcie_phy_pkg::lane_sym_t sym_o
);

  logic [15:0] lfsr_q;
  // symbols left of the unscrambled ts body
  logic [3:0]  plain_cnt_q;
  logic        is_com;
  logic        is_skp;

  assign is_com = sym_i.valid && sym_i.is_k && (sym_i.data == pcie_phy_pkg::SYM_COM);
  assign is_skp = sym_i.valid && sym_i.is_k && (sym_i.data == pcie_phy_pkg::SYM_SKP);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q      <= pcie_phy_pkg::LFSR_SEED;
      plain_cnt_q <= '0;
      sym_o       <= '0;
    end else begin
      // default pass through, data may be replaced below
      sym_o <= sym_i;
      if (is_com) begin
        // reseed, com itself does not advance
        lfsr_q      <= pcie_phy_pkg::LFSR_SEED;
        plain_cnt_q <= 4'(pcie_phy_pkg::TS_LAST);
      end else if (is_skp) begin
        // skp holds the lfsr
        // com then skp is a skip set, so no ts body follows
        plain_cnt_q <= '0;
      end else if (sym_i.valid) begin
        lfsr_q <= pcie_phy_pkg::lfsr_advance(lfsr_q);
        if (plain_cnt_q != '0) begin
          // ts body, sent in the clear
          plain_cnt_q <= plain_cnt_q - 4'd1;
        end else if (!sym_i.is_k) begin
          sym_o.data <= sym_i.data ^ pcie_phy_pkg::lfsr_key(lfsr_q);
        end
      end
    end
  end

endmodule

// ==== ordered_set_handler.sv ====
module ordered_set_handler (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  pcie_phy_pkg::lane_sym_t         sym_i,
  output pcie_phy_pkg::pcie_ordered_set_t ordered_set_o,
  output logic                            ts1_valid_o,
  output logic                            ts2_valid_o,
  output logic                            idle_valid_o
);

  // symbol index in a com-led set, 0 when outside
  logic [3:0] idx_q;
  // identifier still matching so far
  logic       ts1_ok_q;
  logic       ts2_ok_q;
  // fields of the set being collected
  pcie_phy_pkg::pcie_ordered_set_t set_q;
  // idle data symbols in a row, saturates
  logic [3:0] run_q;
  logic       is_com;
  logic       is_idle;
  logic       ts1_hit;
  logic       ts2_hit;

  assign is_com = sym_i.valid && sym_i.is_k && (sym_i.data == pcie_phy_pkg::SYM_COM);
  // descrambled 00 outside a set
  assign is_idle = sym_i.valid && !sym_i.is_k && (sym_i.data == 8'h00) && (idx_q == '0);
  assign ts1_hit = (sym_i.data == pcie_phy_pkg::TS1_ID);
  assign ts2_hit = (sym_i.data == pcie_phy_pkg::TS2_ID);
  assign idle_valid_o = (run_q == 4'(pcie_phy_pkg::IDLE_RUN));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      idx_q         <= '0;
      ts1_ok_q      <= 1'b0;
      ts2_ok_q      <= 1'b0;
      set_q         <= '0;
      ordered_set_o <= '0;
      ts1_valid_o   <= 1'b0;
      ts2_valid_o   <= 1'b0;
      run_q         <= '0;
    end else begin
      ts1_valid_o <= 1'b0;
      ts2_valid_o <= 1'b0;
      if (is_com) begin
        // com always restarts the set
        idx_q    <= 4'd1;
        ts1_ok_q <= 1'b1;
        ts2_ok_q <= 1'b1;
      end else if (sym_i.valid && (idx_q != '0)) begin
        if (sym_i.is_k) begin
          // k in the body, not a training set
          idx_q <= '0;
        end else begin
          case (idx_q)
            4'd1: set_q.link_num      <= sym_i.data;
            4'd2: set_q.lane_num      <= sym_i.data;
            4'd3: set_q.n_fts         <= sym_i.data;
            4'd4: set_q.rate_id       <= sym_i.data;
            4'd5: set_q.training_ctrl <= sym_i.data;
            // raw byte, view chosen by the valid
            4'd6: set_q.sym6          <= sym_i.data;
            default: begin
              // symbols 7 to 15 carry the identifier
              ts1_ok_q <= ts1_ok_q && ts1_hit;
              ts2_ok_q <= ts2_ok_q && ts2_hit;
            end
          endcase
          if (idx_q == 4'(pcie_phy_pkg::TS_LAST)) begin
            idx_q <= '0;
            if (ts1_ok_q && ts1_hit) begin
              ordered_set_o <= set_q;
              ts1_valid_o   <= 1'b1;
            end else if (ts2_ok_q && ts2_hit) begin
              ordered_set_o <= set_q;
              ts2_valid_o   <= 1'b1;
            end
          end else begin
            idx_q <= idx_q + 4'd1;
          end
        end
      end
      // any other symbol breaks the idle run
      if (sym_i.valid) begin
        if (!is_idle) begin
          run_q <= '0;
        end else if (run_q != 4'(pcie_phy_pkg::IDLE_RUN)) begin
          run_q <= run_q + 4'd1;
        end
      end
    end
  end

endmodule

// ==== lane_packer.sv ====
module lane_packer (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  logic                                                 link_up_i,
  input  pcie_phy_pkg::link_width_e                            link_width_i,
  input  pcie_phy_pkg::lane_sym_t [pcie_phy_pkg::NUM_LANES-1:0] lanes_i,
  output pcie_phy_pkg::phy_word_t                              word_o,
  output logic                                                 wr_o
);

  // partial word and next free slot
  pcie_phy_pkg::word_sym_t [pcie_phy_pkg::WORD_SYMS-1:0] acc_q;
  pcie_phy_pkg::word_sym_t [pcie_phy_pkg::WORD_SYMS-1:0] acc_d;
  logic [1:0]                slot_q;
  pcie_phy_pkg::link_width_e width_q;
  logic                      changed;
  logic [1:0]                base;
  logic [2:0]                step;
  logic [2:0]                fill;
  logic                      take;
  logic [1:0]                pos;

  // lanes consumed per valid cycle
  always_comb begin
    case (link_width_i)
      pcie_phy_pkg::WIDTH_X1: step = 3'd1;
      pcie_phy_pkg::WIDTH_X2: step = 3'd2;
      default:                step = 3'd4;
    endcase
  end

  // skp is removed here so it never lands in a word
  assign take = lanes_i[0].valid &&
                !(lanes_i[0].is_k && (lanes_i[0].data == pcie_phy_pkg::SYM_SKP));
  // new width restarts at slot 0 without losing this cycle
  assign changed = (link_width_i != width_q);
  assign base    = changed ? 2'd0 : slot_q;
  assign fill    = {1'b0, base} + step;

  // place active lanes after the filled slots
  always_comb begin
    acc_d = acc_q;
    for (int i = 0; i < pcie_phy_pkg::NUM_LANES; i++) begin
      pos = base + 2'(i);
      if (3'(i) < step) begin
        acc_d[pos].data = lanes_i[i].data;
        acc_d[pos].is_k = lanes_i[i].is_k;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      slot_q  <= '0;
      wr_o    <= 1'b0;
      width_q <= pcie_phy_pkg::WIDTH_X4;
    end else begin
      width_q <= link_width_i;
      wr_o    <= 1'b0;
      if (!link_up_i) begin
        slot_q <= '0;
      end else if (take) begin
        // carry out of slot 1 means the word is full
        slot_q <= fill[1:0];
        wr_o   <= fill[2];
      end else if (changed) begin
        slot_q <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      acc_q <= acc_d;
    end
    if (take && fill[2]) begin
      word_o.sym   <= acc_d;
      word_o.valid <= 1'b1;
    end
  end

endmodule

// ==== sync_fifo.sv ====
module sync_fifo (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    clear_i,
  input  logic                    wr_i,
  input  logic                    rd_i,
  input  pcie_phy_pkg::phy_word_t wdata_i,
  output pcie_phy_pkg::phy_word_t rdata_o,
  output logic                    empty_o,
  output logic                    full_o
);

  pcie_phy_pkg::phy_word_t mem [pcie_phy_pkg::FIFO_DEPTH];
  logic [pcie_phy_pkg::FIFO_AW-1:0] wr_ptr_q;
  logic [pcie_phy_pkg::FIFO_AW-1:0] rd_ptr_q;
  // occupancy, one bit wider than the pointers
  logic [pcie_phy_pkg::FIFO_AW:0]   count_q;
  logic                             do_wr;
  logic                             do_rd;

  // full drops the write, empty ignores the read
  assign do_wr   = wr_i && !full_o;
  assign do_rd   = rd_i && !empty_o;
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (pcie_phy_pkg::FIFO_AW + 1)'(pcie_phy_pkg::FIFO_DEPTH));
  // head shown without a read cycle
  assign rdata_o = mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + do_wr - do_rd;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem[wr_ptr_q] <= wdata_i;
    end
  end

endmodule

// ==== dllp_extractor.sv ====
module dllp_extractor (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     link_up_i,
  input  logic                     empty_i,
  input  pcie_phy_pkg::phy_word_t  word_i,
  output logic                     rd_o,
  output pcie_phy_pkg::dllp_beat_t beat_o,
  output logic                     valid_o,
  input  logic                     ready_i
);

  typedef enum logic [1:0] {
    ST_SEARCH,
    ST_SECOND,
    ST_BEAT1,
    ST_BEAT2
  } state_e;

  state_e                  state_q;
  // sdp word and the word after it
  pcie_phy_pkg::phy_word_t first_q;
  pcie_phy_pkg::phy_word_t second_q;
  logic                    is_sdp;

  // sdp only counts at byte 0
  assign is_sdp = word_i.valid && word_i.sym[0].is_k &&
                  (word_i.sym[0].data == pcie_phy_pkg::SYM_SDP);
  // pop only while collecting, back-pressure leaves words in the fifo
  assign rd_o    = link_up_i && !empty_i && ((state_q == ST_SEARCH) || (state_q == ST_SECOND));
  assign valid_o = (state_q == ST_BEAT1) || (state_q == ST_BEAT2);

  always_ff @(posedge clk_i) begin
    if (rst_i || !link_up_i) begin
      state_q <= ST_SEARCH;
    end else begin
      case (state_q)
        ST_SEARCH: begin
          // non-sdp words are dropped
          if (rd_o && is_sdp) begin
            state_q <= ST_SECOND;
          end
        end
        ST_SECOND: begin
          if (rd_o) begin
            state_q <= ST_BEAT1;
          end
        end
        ST_BEAT1: begin
          if (ready_i) begin
            state_q <= ST_BEAT2;
          end
        end
        default: begin
          if (ready_i) begin
            state_q <= ST_SEARCH;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_SEARCH && rd_o) begin
      first_q <= word_i;
    end
    if (state_q == ST_SECOND && rd_o) begin
      second_q <= word_i;
    end
  end

  // dllp bytes 0-2 in first word slots 1-3, bytes 3-5 in second word slots 0-2
  always_comb begin
    beat_o = '0;
    if (state_q == ST_BEAT2) begin
      beat_o.tdata = {16'h0000, second_q.sym[2].data, second_q.sym[1].data};
      beat_o.tkeep = 4'b0011;
      beat_o.tlast = 1'b1;
    end else begin
      beat_o.tdata = {second_q.sym[0].data, first_q.sym[3].data,
                      first_q.sym[2].data, first_q.sym[1].data};
      beat_o.tkeep = 4'b1111;
    end
    // flagged on both beats
    beat_o.bad_end = !(second_q.sym[3].is_k && (second_q.sym[3].data == pcie_phy_pkg::SYM_END));
  end

endmodule

// ==== phy_receive.sv ====
module phy_receive (
  input  logic                                                         clk_i,
  input  logic                                                         rst_i,
  input  logic                                                         link_up_i,
  input  pcie_phy_pkg::link_width_e                                    link_width_i,
  input  pcie_phy_pkg::lane_sym_t         [pcie_phy_pkg::NUM_LANES-1:0] pipe_sym_i,
  output pcie_phy_pkg::pcie_ordered_set_t [pcie_phy_pkg::NUM_LANES-1:0] ordered_set_o,
  output logic                            [pcie_phy_pkg::NUM_LANES-1:0] ts1_valid_o,
  output logic                            [pcie_phy_pkg::NUM_LANES-1:0] ts2_valid_o,
  output logic                            [pcie_phy_pkg::NUM_LANES-1:0] idle_valid_o,
  output pcie_phy_pkg::dllp_beat_t                                     m_dllp_o,
  output logic                                                         m_dllp_valid_o,
  input  logic                                                         m_dllp_ready_i
);

  // descrambled symbols, one per lane
  pcie_phy_pkg::lane_sym_t [pcie_phy_pkg::NUM_LANES-1:0] desc_sym;
  // packer to fifo
  pcie_phy_pkg::phy_word_t pack_word;
  logic                    pack_wr;
  // fifo to extractor
  pcie_phy_pkg::phy_word_t fifo_word;
  logic                    fifo_empty;
  logic                    fifo_rd;

  for (genvar lane = 0; lane < pcie_phy_pkg::NUM_LANES; lane++) begin : gen_lane
    lane_descrambler u_descrambler (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .sym_i (pipe_sym_i[lane]),
      .sym_o (desc_sym[lane])
    );

    ordered_set_handler u_os_handler (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .sym_i         (desc_sym[lane]),
      .ordered_set_o (ordered_set_o[lane]),
      .ts1_valid_o   (ts1_valid_o[lane]),
      .ts2_valid_o   (ts2_valid_o[lane]),
      .idle_valid_o  (idle_valid_o[lane])
    );
  end

  lane_packer u_packer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .link_up_i    (link_up_i),
    .link_width_i (link_width_i),
    .lanes_i      (desc_sym),
    .word_o       (pack_word),
    .wr_o         (pack_wr)
  );

  // link down flushes buffered words
  sync_fifo u_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .clear_i (!link_up_i),
    .wr_i    (pack_wr),
    .rd_i    (fifo_rd),
    .wdata_i (pack_word),
    .rdata_o (fifo_word),
    .empty_o (fifo_empty),
    .full_o  ()
  );

  dllp_extractor u_dllp (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .link_up_i (link_up_i),
    .empty_i   (fifo_empty),
    .word_i    (fifo_word),
    .rd_o      (fifo_rd),
    .beat_o    (m_dllp_o),
    .valid_o   (m_dllp_valid_o),
    .ready_i   (m_dllp_ready_i)
  );

endmodule

// ==== tb_phy_receive.sv ====
module tb_phy_receive;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 200;
  localparam int NUM_DLLP = pcie_phy_pkg::FIFO_DEPTH / 2;

  logic clk_i;
  logic rst_i;
  logic link_up_i;
  logic m_dllp_ready_i;
  logic m_dllp_valid_o;
  logic [3:0] ts1_valid_o;
  logic [3:0] ts2_valid_o;
  logic [3:0] idle_valid_o;
  pcie_phy_pkg::link_width_e link_width_i;
  pcie_phy_pkg::lane_sym_t [pcie_phy_pkg::NUM_LANES-1:0] pipe_sym_i;
  pcie_phy_pkg::pcie_ordered_set_t [pcie_phy_pkg::NUM_LANES-1:0] ordered_set_o;
  pcie_phy_pkg::dllp_beat_t m_dllp_o;

  // transmitter lfsr and clear-symbol count per lane
  logic [15:0] tx_lfsr [pcie_phy_pkg::NUM_LANES];
  int tx_plain [pcie_phy_pkg::NUM_LANES];
  // expected beats in arrival order
  pcie_phy_pkg::dllp_beat_t exp_q [$];
  logic [47:0] dllp_bytes [NUM_DLLP];
  int seed = 32'h51b1;
  int errors = 0;
  int checks = 0;
  int lanes_on = 4;
  bit bp_mode = 0;
  bit ts1_allowed = 0;
  bit ts2_allowed = 0;

  phy_receive u_dut (
    .clk_i (clk_i), .rst_i (rst_i), .link_up_i (link_up_i), .link_width_i (link_width_i),
    .pipe_sym_i (pipe_sym_i), .ordered_set_o (ordered_set_o), .ts1_valid_o (ts1_valid_o),
    .ts2_valid_o (ts2_valid_o), .idle_valid_o (idle_valid_o), .m_dllp_o (m_dllp_o),
    .m_dllp_valid_o (m_dllp_valid_o), .m_dllp_ready_i (m_dllp_ready_i)
  );

  always #4 clk_i = ~clk_i;

  // stalled beat must stay valid and unchanged
  assert property (@(posedge clk_i) disable iff (rst_i)
    m_dllp_valid_o && !m_dllp_ready_i |=> m_dllp_valid_o && $stable(m_dllp_o))
    else begin
      errors++;
      $display("DLLP beat changed or dropped while stalled at %0t", $time);
    end
  assert property (@(posedge clk_i) disable iff (rst_i) !ts1_allowed |-> ts1_valid_o == '0)
    else begin
      errors++;
      $display("unexpected ts1_valid_o pulse at %0t", $time);
    end
  assert property (@(posedge clk_i) disable iff (rst_i) !ts2_allowed |-> ts2_valid_o == '0)
    else begin
      errors++;
      $display("unexpected ts2_valid_o pulse at %0t", $time);
    end

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Fail %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_true(input string what, input bit ok);
    checks++;
    assert (ok) else begin
      errors++;
      $display("%s at %0t", what, $time);
    end
  endtask

  // scoreboard, compares every transferred beat
  always @(posedge clk_i) begin : beat_monitor
    pcie_phy_pkg::dllp_beat_t exp_beat;
    if (!rst_i && m_dllp_valid_o && m_dllp_ready_i) begin
      check_true("DLLP beat arrived with none expected", exp_q.size() != 0);
      if (exp_q.size() != 0) begin
        exp_beat = exp_q.pop_front();
        check_val("m_dllp_o", exp_beat, m_dllp_o);
      end
    end
  end

  // transmitter side of one lane, x16+x5+x4+x3+1 shifted msb first
  task automatic encode(input int l, input logic [7:0] d, input logic k,
                        output pcie_phy_pkg::lane_sym_t s);
    logic [7:0] key;
    s.data = d;
    s.is_k = k;
    s.valid = 1'b1;
    if (k && d == pcie_phy_pkg::SYM_COM) begin
      tx_lfsr[l] = 16'hFFFF;
      tx_plain[l] = 15;
    end else if (k && d == pcie_phy_pkg::SYM_SKP) begin
      tx_plain[l] = 0;
    end else begin
      for (int b = 0; b < 8; b++) begin
        key[b] = tx_lfsr[l][15];
        tx_lfsr[l] = {tx_lfsr[l][14:0], 1'b0} ^ (tx_lfsr[l][15] ? 16'h0039 : 16'h0000);
      end
      // ts body goes in the clear
      if (tx_plain[l] > 0) tx_plain[l]--;
      else if (!k) s.data = d ^ key;
    end
  endtask

  // one symbol per enabled lane, then one clock
  task automatic send_cycle(input logic [31:0] d, input logic [3:0] k, input logic [3:0] v);
    pcie_phy_pkg::lane_sym_t s;
    for (int l = 0; l < pcie_phy_pkg::NUM_LANES; l++) begin
      s = '0;
      if (v[l]) encode(l, d[8*l +: 8], k[l], s);
      pipe_sym_i[l] = s;
    end
    m_dllp_ready_i = bp_mode ? 1'($random(seed)) : 1'b1;
    @(negedge clk_i);
  endtask

  // com, five fields, symbol 6, then the identifier on symbols 7 to 15
  task automatic send_ts(input pcie_phy_pkg::pcie_ordered_set_t os, input logic [7:0] id,
                         input bit corrupt);
    logic [7:0] b;
    for (int i = 0; i < 16; i++) begin
      case (i)
        0: b = pcie_phy_pkg::SYM_COM;
        1: b = os.link_num;
        2: b = os.lane_num;
        3: b = os.n_fts;
        4: b = os.rate_id;
        5: b = os.training_ctrl;
        6: b = os.sym6;
        default: b = (corrupt && i == 11) ? ~id : id;
      endcase
      send_cycle({4{b}}, (i == 0) ? 4'hF : 4'h0, 4'hF);
    end
    pipe_sym_i = '0;
  endtask

  // sdp, six bytes, end; striped over the active lanes
  task automatic send_dllp(input logic [47:0] bytes, input bit good_end);
    logic [7:0] sd [8];
    logic [7:0] kb;
    logic [31:0] d;
    logic [3:0] k;
    sd[0] = pcie_phy_pkg::SYM_SDP;
    for (int i = 1; i <= 6; i++) sd[i] = bytes[8*(i-1) +: 8];
    // bad end is a plain data byte
    sd[7] = pcie_phy_pkg::SYM_END;
    kb = {good_end, 6'b0, 1'b1};
    exp_q.push_back('{tdata: bytes[31:0], tkeep: 4'hF, tlast: 1'b0, bad_end: !good_end});
    exp_q.push_back('{tdata: {16'h0, bytes[47:32]}, tkeep: 4'h3, tlast: 1'b1,
                      bad_end: !good_end});
    for (int c = 0; c < 8 / lanes_on; c++) begin
      d = '0;
      k = '0;
      for (int l = 0; l < lanes_on; l++) begin
        d[8*l +: 8] = sd[c*lanes_on + l];
        k[l] = kb[c*lanes_on + l];
      end
      send_cycle(d, k, 4'((1 << lanes_on) - 1));
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    pipe_sym_i = '0;
    while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
      m_dllp_ready_i = bp_mode ? 1'($random(seed)) : 1'b1;
      @(negedge clk_i);
      n++;
    end
    check_true("timeout waiting for DLLP beats", exp_q.size() == 0);
  endtask

  // width changes only on a quiet link
  task automatic set_width(input pcie_phy_pkg::link_width_e w, input int n);
    pipe_sym_i = '0;
    link_width_i = w;
    lanes_on = n;
    repeat (2) @(negedge clk_i);
  endtask

  initial begin
    pcie_phy_pkg::pcie_ordered_set_t os;
    logic [63:0] raw;
    int n;
    clk_i = 1'b0;
    rst_i = 1'b1;
    link_up_i = 1'b0;
    link_width_i = pcie_phy_pkg::WIDTH_X4;
    pipe_sym_i = '0;
    m_dllp_ready_i = 1'b1;
    for (int l = 0; l < pcie_phy_pkg::NUM_LANES; l++) begin
      tx_lfsr[l] = 16'hFFFF;
      tx_plain[l] = 0;
    end
    for (int i = 0; i < NUM_DLLP; i++) begin
      raw = {$random(seed), $random(seed)};
      dllp_bytes[i] = raw[47:0];
    end
    repeat (3) @(negedge clk_i);
    rst_i = 1'b0;
    link_up_i = 1'b1;
    check_val("m_dllp_valid_o", 0, m_dllp_valid_o);
    check_val("idle_valid_o", 0, idle_valid_o);
    check_true("ordered_set_o not zero after reset", ordered_set_o == '0);

    // ts1 then ts2 on all lanes, random fields
    for (int t = 0; t < 2; t++) begin
      raw = {$random(seed), $random(seed)};
      os = raw[39:0];
      ts1_allowed = (t == 0);
      ts2_allowed = (t == 1);
      send_ts(os, (t == 0) ? pcie_phy_pkg::TS1_ID : pcie_phy_pkg::TS2_ID, 1'b0);
      n = 0;
      while (((t == 0) ? ts1_valid_o : ts2_valid_o) != 4'hF && n < WAIT_LIMIT) begin
        @(negedge clk_i);
        n++;
      end
      check_true("timeout waiting for training set valid", n < WAIT_LIMIT);
      for (int l = 0; l < pcie_phy_pkg::NUM_LANES; l++) begin
        check_val("ordered_set_o.link_num", os.link_num, ordered_set_o[l].link_num);
        check_val("ordered_set_o.lane_num", os.lane_num, ordered_set_o[l].lane_num);
        check_val("ordered_set_o.n_fts", os.n_fts, ordered_set_o[l].n_fts);
        check_val("ordered_set_o.rate_id", os.rate_id, ordered_set_o[l].rate_id);
        check_val("ordered_set_o.training_ctrl", os.training_ctrl,
                  ordered_set_o[l].training_ctrl);
        if (t == 0) check_val("ordered_set_o.sym6.ts1", os.sym6.ts1, ordered_set_o[l].sym6.ts1);
        else check_val("ordered_set_o.sym6.ts2", os.sym6.ts2, ordered_set_o[l].sym6.ts2);
      end
      @(negedge clk_i);
      check_val("ts1_valid_o | ts2_valid_o", 0, ts1_valid_o | ts2_valid_o);
      ts1_allowed = 1'b0;
      ts2_allowed = 1'b0;
    end
    // broken identifier, assertions catch any pulse
    send_ts(os, pcie_phy_pkg::TS2_ID, 1'b1);
    repeat (pcie_phy_pkg::IDLE_RUN) @(negedge clk_i);

    // x4, then x2 and x1 with skp gaps
    for (int i = 0; i < NUM_DLLP; i++) send_dllp(dllp_bytes[i], 1'b1);
    wait_drained();
    for (int w = 0; w < 2; w++) begin
      if (w == 0) set_width(pcie_phy_pkg::WIDTH_X2, 2);
      else set_width(pcie_phy_pkg::WIDTH_X1, 1);
      for (int i = 0; i < NUM_DLLP; i++) begin
        send_dllp(dllp_bytes[i], 1'b1);
        n = $unsigned($random(seed)) % 3;
        repeat (n) send_cycle({4{pcie_phy_pkg::SYM_SKP}}, 4'hF, 4'((1 << lanes_on) - 1));
      end
      wait_drained();
    end
    set_width(pcie_phy_pkg::WIDTH_X4, 4);

    // random stalls on ready
    bp_mode = 1'b1;
    for (int i = 0; i < NUM_DLLP; i++) send_dllp(dllp_bytes[i], 1'b1);
    wait_drained();
    bp_mode = 1'b0;
    send_dllp(dllp_bytes[0], 1'b0);
    wait_drained();

    // scrambled idle data on every lane
    n = 0;
    while (idle_valid_o != 4'hF && n < WAIT_LIMIT) begin
      send_cycle(32'h0, 4'h0, 4'hF);
      n++;
    end
    check_true("timeout waiting for idle_valid_o", idle_valid_o == 4'hF);
    check_true("idle_valid_o rose before a full idle run", n >= pcie_phy_pkg::IDLE_RUN);
    send_cycle({4{pcie_phy_pkg::SYM_SKP}}, 4'hF, 4'hF);
    pipe_sym_i = '0;
    n = 0;
    while (idle_valid_o != 4'h0 && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    check_val("idle_valid_o", 0, idle_valid_o);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
pcie_phy_pkg.sv
lane_descrambler.sv
ordered_set_handler.sv
lane_packer.sv
sync_fifo.sv
dllp_extractor.sv
phy_receive.sv
tb_phy_receive.sv
